//--- all.f
+incdir+include
design/image_pkg.sv
design/conv_pkg.sv
design/credit_fifo.sv
design/pixel_shifter.sv
design/weights_packer.sv
design/conv_input_joiner.sv
design/axis_input_pipe.sv
testbench/input_pipe_tb.sv

//--- design/axis_input_pipe.sv
`default_nettype none

`include "conv_config.svh"

module axis_input_pipe
  import image_pkg::*;
  import conv_pkg::*;
(
  input  logic         aclk,
  input  logic         reset,
  input  image_beat_t  s_image,
  input  logic         s_image_valid,
  output logic         s_image_ready,
  input  weight_beat_t s_weights,
  input  logic         s_weights_valid,
  output logic         s_weights_ready,
  output conv_beat_t   m_conv,
  output logic         m_conv_valid,
  input  logic         m_conv_ready
);

  // pixel path.
  logic        pixel_push;
  pixel_row_t  pixel_push_data;
  logic        pixel_credit;
  pixel_row_t  pixel_pop_data;
  logic        pixel_empty;

  // weight path.
  logic        weight_push;
  weight_row_t weight_push_data;
  logic        weight_credit;
  weight_row_t weight_pop_data;
  logic        weight_empty;

  logic        pop; // shared by both buffers.

  // **************************************************
  // producers
  // **************************************************
  pixel_shifter u_pixel_shifter (
    .aclk          (aclk),
    .reset         (reset),
    .s_image       (s_image),
    .s_image_valid (s_image_valid),
    .s_image_ready (s_image_ready),
    .push          (pixel_push),
    .push_data     (pixel_push_data),
    .credit        (pixel_credit)
  );

  weights_packer u_weights_packer (
    .aclk            (aclk),
    .reset           (reset),
    .s_weights       (s_weights),
    .s_weights_valid (s_weights_valid),
    .s_weights_ready (s_weights_ready),
    .push            (weight_push),
    .push_data       (weight_push_data),
    .credit          (weight_credit)
  );

  // **************************************************
  // buffers and join
  // **************************************************
  credit_fifo #(.payload_t(pixel_row_t)) u_pixel_fifo (
    .aclk      (aclk),
    .reset     (reset),
    .push      (pixel_push),
    .push_data (pixel_push_data),
    .pop       (pop),
    .pop_data  (pixel_pop_data),
    .empty     (pixel_empty),
    .credit    (pixel_credit)
  );

  credit_fifo #(.payload_t(weight_row_t)) u_weight_fifo (
    .aclk      (aclk),
    .reset     (reset),
    .push      (weight_push),
    .push_data (weight_push_data),
    .pop       (pop),
    .pop_data  (weight_pop_data),
    .empty     (weight_empty),
    .credit    (weight_credit)
  );

  conv_input_joiner u_joiner (
    .aclk         (aclk),
    .reset        (reset),
    .pixel_data   (pixel_pop_data),
    .pixel_empty  (pixel_empty),
    .weight_data  (weight_pop_data),
    .weight_empty (weight_empty),
    .pop          (pop),
    .m_conv       (m_conv),
    .m_conv_valid (m_conv_valid),
    .m_conv_ready (m_conv_ready)
  );

endmodule

`default_nettype wire

//--- design/conv_input_joiner.sv
`default_nettype none

module conv_input_joiner
  import image_pkg::*;
  import conv_pkg::*;
(
  input  logic        aclk,
  input  logic        reset,
  input  pixel_row_t  pixel_data,
  input  logic        pixel_empty,
  input  weight_row_t weight_data,
  input  logic        weight_empty,
  output logic        pop,
  output conv_beat_t  m_conv,
  output logic        m_conv_valid,
  input  logic        m_conv_ready
);

  conv_beat_t next_beat;
  logic       out_free;

  // output register can take a new beat.
  assign out_free = m_conv_ready || !m_conv_valid;

  // both buffers pop together.
  assign pop = !pixel_empty && !weight_empty && out_free;

  // **************************************************
  // merge pixel row and weight row
  // **************************************************
  always_comb begin
    next_beat.pixels           = pixel_data.words;
    next_beat.weights          = weight_data.words;
    next_beat.user.is_max      = pixel_data.is_max;
    next_beat.user.is_lrelu    = pixel_data.is_lrelu;
    next_beat.user.is_acc_last = weight_data.is_acc_last;
    next_beat.user.row_last    = pixel_data.row_last;
    next_beat.last             = pixel_data.last;
  end

  always_ff @(posedge aclk) begin
    if (pop) m_conv <= next_beat;
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      m_conv_valid <= 1'b0;
    end else if (pop) begin
      m_conv_valid <= 1'b1;
    end else if (m_conv_ready) begin
      m_conv_valid <= 1'b0; // drained with nothing new to load.
    end
  end

endmodule

`default_nettype wire

//--- design/conv_pkg.sv
`default_nettype none

`include "conv_config.svh"

package conv_pkg;

  typedef struct packed {
    logic [`W_BEAT_WORDS-1:0][`WORD_WIDTH-1:0] words;
    logic                                      is_acc_last;
  } weight_beat_t;

  // word index is core*KERNEL_W_MAX + kernel column.
  typedef struct packed {
    logic [`CORES*`KERNEL_W_MAX-1:0][`WORD_WIDTH-1:0] words;
    logic                                             is_acc_last;
  } weight_row_t;

  typedef struct packed {
    logic is_max;
    logic is_lrelu;
    logic is_acc_last;
    logic row_last;
  } conv_tuser_t;

  // beat handed to the conv engine.
  typedef struct packed {
    logic [`UNITS-1:0][`WORD_WIDTH-1:0]               pixels;
    logic [`CORES*`KERNEL_W_MAX-1:0][`WORD_WIDTH-1:0] weights;
    conv_tuser_t                                      user;
    logic                                             last;
  } conv_beat_t;

endpackage

`default_nettype wire

//--- design/credit_fifo.sv
`default_nettype none

`include "conv_config.svh"

module credit_fifo #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     credit
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  payload_t         mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];

  // the producer only pushes with credit in hand.
  always_ff @(posedge aclk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit <= pop; // one credit back per freed entry.
    end
  end

endmodule

`default_nettype wire

//--- design/image_pkg.sv
`default_nettype none

`include "conv_config.svh"

package image_pkg;

  // one input beat holds all words a kernel column can touch.
  typedef struct packed {
    logic [`UNITS_EDGES-1:0][`WORD_WIDTH-1:0] words;
    logic                                     is_max;
    logic                                     is_lrelu;
    logic [$clog2(`KERNEL_H_MAX)-1:0]         kernel_h_1; // kernel height minus one.
    logic                                     last;
  } image_beat_t;

  // one kernel row worth of pixels.
  typedef struct packed {
    logic [`UNITS-1:0][`WORD_WIDTH-1:0] words;
    logic                               is_max;
    logic                               is_lrelu;
    logic                               row_last; // final kernel row of the beat.
    logic                               last;
  } pixel_row_t;

endpackage

`default_nettype wire

//--- design/pixel_shifter.sv
`default_nettype none

`include "conv_config.svh"

module pixel_shifter
  import image_pkg::*;
(
  input  logic        aclk,
  input  logic        reset,
  input  image_beat_t s_image,
  input  logic        s_image_valid,
  output logic        s_image_ready,
  output logic        push,
  output pixel_row_t  push_data,
  input  logic        credit
);

  localparam int CREDIT_W = $clog2(`FIFO_DEPTH + 1);
  localparam int ROW_W    = $clog2(`KERNEL_H_MAX);

  image_beat_t         beat_q;
  logic                busy;
  logic [ROW_W-1:0]    row;
  logic [CREDIT_W-1:0] credits;
  logic                accept;
  logic                row_last;

  assign accept   = s_image_valid && s_image_ready;
  assign row_last = (row == beat_q.kernel_h_1);
  assign push     = busy && (credits != '0); // stall on the current row without credit.

  // row r takes words r to r+UNITS-1.
  always_comb begin
    for (int i = 0; i < `UNITS; i++) begin
      push_data.words[i] = beat_q.words[row + i];
    end
    push_data.is_max   = beat_q.is_max;
    push_data.is_lrelu = beat_q.is_lrelu;
    push_data.row_last = row_last;
    push_data.last     = beat_q.last && row_last;
  end

  always_ff @(posedge aclk) begin
    if (accept) beat_q <= s_image;
  end

  // **************************************************
  // row sequencing
  // **************************************************
  always_ff @(posedge aclk) begin
    if (reset) begin
      s_image_ready <= 1'b0;
      busy          <= 1'b0;
      row           <= '0;
    end else if (accept) begin
      s_image_ready <= 1'b0;
      busy          <= 1'b1;
      row           <= '0;
    end else if (push) begin
      if (row_last) begin
        busy          <= 1'b0;
        s_image_ready <= 1'b1; // ready again right after the last row.
      end else begin
        row <= row + 1'b1;
      end
    end else if (!busy) begin
      s_image_ready <= 1'b1;
    end
  end

  // credits held toward the pixel buffer.
  always_ff @(posedge aclk) begin
    if (reset) begin
      credits <= CREDIT_W'(`FIFO_DEPTH);
    end else begin
      case ({push, credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/weights_packer.sv
`default_nettype none

`include "conv_config.svh"

module weights_packer
  import conv_pkg::*;
(
  input  logic         aclk,
  input  logic         reset,
  input  weight_beat_t s_weights,
  input  logic         s_weights_valid,
  output logic         s_weights_ready,
  output logic         push,
  output weight_row_t  push_data,
  input  logic         credit
);

  localparam int CREDIT_W = $clog2(`FIFO_DEPTH + 1);
  localparam int CNT_W    = $clog2(`W_BEATS_PER_ROW);

  weight_row_t         row_q;
  logic [CNT_W-1:0]    cnt;
  logic                full;
  logic [CREDIT_W-1:0] credits;
  logic                accept;
  logic                beat_last;

  assign push            = full && (credits != '0);
  assign s_weights_ready = !full || push; // one beat of the next group may enter during a push.
  assign accept          = s_weights_valid && s_weights_ready;
  assign beat_last       = (cnt == CNT_W'(`W_BEATS_PER_ROW - 1));
  assign push_data       = row_q;

  // beat j lands on words 2j and 2j+1.
  always_ff @(posedge aclk) begin
    if (accept) begin
      for (int k = 0; k < `W_BEAT_WORDS; k++) begin
        row_q.words[cnt*`W_BEAT_WORDS + k] <= s_weights.words[k];
      end
      if (beat_last) row_q.is_acc_last <= s_weights.is_acc_last;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      cnt  <= '0;
      full <= 1'b0;
    end else begin
      if (accept) cnt <= beat_last ? '0 : cnt + 1'b1;
      if (accept && beat_last) full <= 1'b1;
      else if (push)           full <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      credits <= CREDIT_W'(`FIFO_DEPTH);
    end else begin
      case ({push, credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- include/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// word and array sizes.
`define WORD_WIDTH      8
`define UNITS           2
`define KERNEL_H_MAX    3
`define KERNEL_W_MAX    3
`define CORES           2

// an image beat carries the edge words above and below the units.
`define UNITS_EDGES     (`UNITS + `KERNEL_H_MAX - 1)

// weights arrive narrow and are packed into one row for all cores.
`define W_BEAT_WORDS    2
`define W_BEATS_PER_ROW (`CORES * `KERNEL_W_MAX / `W_BEAT_WORDS)

// buffer entries and the credits each producer starts with.
`define FIFO_DEPTH      4

`endif

//--- testbench/input_pipe_tb.sv
`default_nettype none

`include "conv_config.svh"

module input_pipe_tb
  import image_pkg::*;
  import conv_pkg::*;
();

  localparam int NUM_ENTRIES = 6;
  localparam int WAIT_LIMIT  = 200; // cycles allowed for any single wait.

  logic         aclk;
  logic         reset;
  image_beat_t  s_image;
  logic         s_image_valid;
  logic         s_image_ready;
  weight_beat_t s_weights;
  logic         s_weights_valid;
  logic         s_weights_ready;
  conv_beat_t   m_conv;
  logic         m_conv_valid;
  logic         m_conv_ready;

  image_beat_t  stim_table [NUM_ENTRIES];
  weight_beat_t wbeat_q [$]; // weight beats of the current entry.
  conv_beat_t   exp_q [$];
  logic [31:0]  weight_seed;
  logic [31:0]  ready_seed;
  int           error_count;
  int           output_count;
  int           entries_run;
  bit           timed_out;

  axis_input_pipe DUT (
    .aclk            (aclk),
    .reset           (reset),
    .s_image         (s_image),
    .s_image_valid   (s_image_valid),
    .s_image_ready   (s_image_ready),
    .s_weights       (s_weights),
    .s_weights_valid (s_weights_valid),
    .s_weights_ready (s_weights_ready),
    .m_conv          (m_conv),
    .m_conv_valid    (m_conv_valid),
    .m_conv_ready    (m_conv_ready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // random back-pressure on the output.
  initial begin
    @(posedge aclk);
    forever begin
      @(negedge aclk);
      ready_seed   = lcg_next(ready_seed);
      m_conv_ready = ready_seed[17];
    end
  end

  // **************************************************
  // stimulus and expected beats
  // **************************************************
  task automatic plan_entry(input image_beat_t beat);
    weight_beat_t wb;
    conv_beat_t   exp_beat;
    wbeat_q.delete();
    for (int r = 0; r <= beat.kernel_h_1; r++) begin
      for (int j = 0; j < `W_BEATS_PER_ROW; j++) begin
        for (int k = 0; k < `W_BEAT_WORDS; k++) begin
          weight_seed = lcg_next(weight_seed);
          wb.words[k] = weight_seed[23:16];
          exp_beat.weights[j*`W_BEAT_WORDS + k] = weight_seed[23:16]; // core-major.
        end
        wb.is_acc_last = weight_seed[9];
        wbeat_q.push_back(wb);
      end
      for (int i = 0; i < `UNITS; i++) begin
        exp_beat.pixels[i] = beat.words[r + i];
      end
      exp_beat.user.is_max      = beat.is_max;
      exp_beat.user.is_lrelu    = beat.is_lrelu;
      exp_beat.user.is_acc_last = wb.is_acc_last; // from the third beat of the group.
      exp_beat.user.row_last    = (r == beat.kernel_h_1);
      exp_beat.last             = beat.last && (r == beat.kernel_h_1);
      exp_q.push_back(exp_beat);
    end
  endtask

  task automatic send_image(input image_beat_t beat);
    int cycles;
    cycles = 0;
    @(negedge aclk);
    s_image       = beat;
    s_image_valid = 1'b1;
    do begin
      @(posedge aclk);
      cycles++;
    end while (!s_image_ready && cycles < WAIT_LIMIT);
    if (!s_image_ready) begin
      $display("timeout: image beat was not accepted within %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
    end
    @(negedge aclk);
    s_image_valid = 1'b0;
  endtask

  task automatic send_weights();
    int cycles;
    foreach (wbeat_q[n]) begin
      cycles = 0;
      @(negedge aclk);
      s_weights       = wbeat_q[n];
      s_weights_valid = 1'b1;
      do begin
        @(posedge aclk);
        cycles++;
      end while (!s_weights_ready && cycles < WAIT_LIMIT);
      if (!s_weights_ready) begin
        $display("timeout: weight beat %0d was not accepted within %0d cycles", n, WAIT_LIMIT);
        timed_out = 1'b1;
      end
    end
    @(negedge aclk);
    s_weights_valid = 1'b0;
  endtask

  // **************************************************
  // output scoreboard
  // **************************************************
  always @(posedge aclk) begin
    conv_beat_t exp_beat;
    if (!reset && m_conv_valid && m_conv_ready) begin
      output_count++;
      if (exp_q.size() == 0) begin
        $display("an output beat arrived when none was expected");
        error_count++;
      end else begin
        exp_beat = exp_q.pop_front();
        if (m_conv.pixels !== exp_beat.pixels) begin
          $display("[ERROR] m_conv.pixels expected %h actual %h", exp_beat.pixels, m_conv.pixels);
          error_count++;
        end
        if (m_conv.weights !== exp_beat.weights) begin
          $display("[ERROR] m_conv.weights expected %h actual %h",
                   exp_beat.weights, m_conv.weights);
          error_count++;
        end
        if (m_conv.user !== exp_beat.user) begin
          $display("[ERROR] m_conv.user expected %h actual %h", exp_beat.user, m_conv.user);
          error_count++;
        end
        if (m_conv.last !== exp_beat.last) begin
          $display("[ERROR] m_conv.last expected %h actual %h", exp_beat.last, m_conv.last);
          error_count++;
        end
      end
    end
  end

  initial begin
    int cycles;
    int errors_before;
    int outputs_before;
    reset           = 1'b1;
    s_image         = '0;
    s_image_valid   = 1'b0;
    s_weights       = '0;
    s_weights_valid = 1'b0;
    m_conv_ready    = 1'b0;
    weight_seed     = 32'd63379;
    ready_seed      = 32'd63379;
    error_count     = 0;
    output_count    = 0;
    entries_run     = 0;
    timed_out       = 1'b0;

    // words are listed high word first.
    stim_table[0] = '{words: 32'h44332211, is_max: 0, is_lrelu: 0, kernel_h_1: 2, last: 0};
    stim_table[1] = '{words: 32'h0d0c0b0a, is_max: 1, is_lrelu: 0, kernel_h_1: 0, last: 1};
    stim_table[2] = '{words: 32'ha4a3a2a1, is_max: 0, is_lrelu: 1, kernel_h_1: 1, last: 0};
    stim_table[3] = '{words: 32'hf0e0d0c0, is_max: 1, is_lrelu: 1, kernel_h_1: 2, last: 1};
    stim_table[4] = '{words: 32'h87654321, is_max: 0, is_lrelu: 0, kernel_h_1: 0, last: 0};
    stim_table[5] = '{words: 32'h5566ff00, is_max: 0, is_lrelu: 1, kernel_h_1: 2, last: 1};

    repeat (5) @(posedge aclk);
    @(negedge aclk);
    reset = 1'b0;

    for (int e = 0; e < NUM_ENTRIES && !timed_out; e++) begin
      errors_before  = error_count;
      outputs_before = output_count;
      plan_entry(stim_table[e]);
      fork
        send_image(stim_table[e]);
        send_weights();
      join
      cycles = 0;
      while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
        @(negedge aclk);
        cycles++;
      end
      if (exp_q.size() != 0) begin
        $display("timeout: %0d output beats of entry %0d never arrived", exp_q.size(), e);
        timed_out = 1'b1;
      end
      if (timed_out) error_count++;
      entries_run++;
      $display("entry %0d: kernel height %0d, %0d outputs, %s", e,
               stim_table[e].kernel_h_1 + 1, output_count - outputs_before,
               (error_count == errors_before) ? "ok" : "failed");
    end

    // a stray extra beat would show up here.
    repeat (8) @(negedge aclk);
    $display("entries %0d, outputs %0d, errors %0d", entries_run, output_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
